/* Makefile */
# Verilator build and run of the rename subsystem testbench
VERILATOR ?= verilator
TOP       ?= renameCoreTb
BUILD     ?= obj_dir
LOG       ?= sim.log
FLIST     ?= renameCore.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(wildcard rtl/*.sv) $(wildcard test/*.sv)
SIM  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -o V$(TOP) -f $(FLIST)

run: $(SIM)
	$(SIM) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* renameCore.f */
rtl/renamePkg.sv
rtl/recoverPkg.sv
rtl/mapRam4r4w.sv
rtl/archMapTable.sv
rtl/specFreeList.sv
rtl/renameMapTable.sv
rtl/renameCore.sv
test/renameCoreTb.sv

/* rtl/archMapTable.sv */
/* committed map, updated by up to four retiring instructions per cycle
   slot 0 is the oldest; a valid bit means the slot has a destination
   release outputs are combinational and valid in the commit cycle
   after a recover_i strobe the map streams out four entries per cycle
   for recoverSteps cycles; no commits may arrive during that time */
module archMapTable (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              commitValid0_i,
  input  logic                              commitValid1_i,
  input  logic                              commitValid2_i,
  input  logic                              commitValid3_i,
  input  logic [renamePkg::logRegBits-1:0]  commitLogDest0_i,
  input  logic [renamePkg::logRegBits-1:0]  commitLogDest1_i,
  input  logic [renamePkg::logRegBits-1:0]  commitLogDest2_i,
  input  logic [renamePkg::logRegBits-1:0]  commitLogDest3_i,
  input  logic [renamePkg::physRegBits-1:0] commitPhysDest0_i,
  input  logic [renamePkg::physRegBits-1:0] commitPhysDest1_i,
  input  logic [renamePkg::physRegBits-1:0] commitPhysDest2_i,
  input  logic [renamePkg::physRegBits-1:0] commitPhysDest3_i,
  input  logic                              recover_i,
  output logic                              releasedValid0_o,
  output logic                              releasedValid1_o,
  output logic                              releasedValid2_o,
  output logic                              releasedValid3_o,
  output logic [renamePkg::physRegBits-1:0] releasedPhys0_o,
  output logic [renamePkg::physRegBits-1:0] releasedPhys1_o,
  output logic [renamePkg::physRegBits-1:0] releasedPhys2_o,
  output logic [renamePkg::physRegBits-1:0] releasedPhys3_o,
  output logic                              recoverBusy_o,
  output logic                              recoverWe_o,
  output logic [renamePkg::logRegBits-1:0]  recoverBase_o,
  output logic [renamePkg::physRegBits-1:0] recoverPhys0_o,
  output logic [renamePkg::physRegBits-1:0] recoverPhys1_o,
  output logic [renamePkg::physRegBits-1:0] recoverPhys2_o,
  output logic [renamePkg::physRegBits-1:0] recoverPhys3_o
);
  import renamePkg::*;
  import recoverPkg::*;

  recoverState_t                   state;
  logic [$clog2(recoverSteps)-1:0] stepCnt;                   // group of four being copied
  logic                            copying;
  logic                            squash0, squash1, squash2; // slot 3 is youngest
  logic [logRegBits-1:0]           rdAddr0, rdAddr1, rdAddr2, rdAddr3;
  logic [physRegBits-1:0]          rdData0, rdData1, rdData2, rdData3;

  // a slot is squashed when a valid younger slot writes the same logical reg
  assign squash0 = (commitValid1_i && (commitLogDest0_i == commitLogDest1_i)) ||
                   (commitValid2_i && (commitLogDest0_i == commitLogDest2_i)) ||
                   (commitValid3_i && (commitLogDest0_i == commitLogDest3_i));
  assign squash1 = (commitValid2_i && (commitLogDest1_i == commitLogDest2_i)) ||
                   (commitValid3_i && (commitLogDest1_i == commitLogDest3_i));
  assign squash2 = commitValid3_i && (commitLogDest2_i == commitLogDest3_i);

  assign copying       = (state == recCopy);
  assign recoverBase_o = {stepCnt, 2'b00};  // logical regs 4k..4k+3

  // read ports look up old mappings at commit, or feed the copy stream
  assign rdAddr0 = copying ? {stepCnt, 2'd0} : commitLogDest0_i;
  assign rdAddr1 = copying ? {stepCnt, 2'd1} : commitLogDest1_i;
  assign rdAddr2 = copying ? {stepCnt, 2'd2} : commitLogDest2_i;
  assign rdAddr3 = copying ? {stepCnt, 2'd3} : commitLogDest3_i;

  mapRam4r4w i_amt (
    .clk       (clk),
    .reset     (reset),
    .rdAddr0_i (rdAddr0),
    .rdAddr1_i (rdAddr1),
    .rdAddr2_i (rdAddr2),
    .rdAddr3_i (rdAddr3),
    .rdData0_o (rdData0),
    .rdData1_o (rdData1),
    .rdData2_o (rdData2),
    .rdData3_o (rdData3),
    .we0_i     (commitValid0_i && !squash0),  // only the youngest writer updates
    .we1_i     (commitValid1_i && !squash1),
    .we2_i     (commitValid2_i && !squash2),
    .we3_i     (commitValid3_i),
    .wrAddr0_i (commitLogDest0_i),
    .wrAddr1_i (commitLogDest1_i),
    .wrAddr2_i (commitLogDest2_i),
    .wrAddr3_i (commitLogDest3_i),
    .wrData0_i (commitPhysDest0_i),
    .wrData1_i (commitPhysDest1_i),
    .wrData2_i (commitPhysDest2_i),
    .wrData3_i (commitPhysDest3_i)
  );

  // squashed slot gives back its own new reg, else the superseded mapping
  assign releasedValid0_o = commitValid0_i;
  assign releasedValid1_o = commitValid1_i;
  assign releasedValid2_o = commitValid2_i;
  assign releasedValid3_o = commitValid3_i;
  assign releasedPhys0_o  = squash0 ? commitPhysDest0_i : rdData0;
  assign releasedPhys1_o  = squash1 ? commitPhysDest1_i : rdData1;
  assign releasedPhys2_o  = squash2 ? commitPhysDest2_i : rdData2;
  assign releasedPhys3_o  = rdData3;

  assign recoverBusy_o  = copying;
  assign recoverWe_o    = copying;  // one rename map write group per cycle
  assign recoverPhys0_o = rdData0;
  assign recoverPhys1_o = rdData1;
  assign recoverPhys2_o = rdData2;
  assign recoverPhys3_o = rdData3;

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= recIdle;
      stepCnt <= '0;
    end else begin
      case (state)
        recIdle: begin
          stepCnt <= '0;
          if (recover_i) state <= recCopy;  // busy from the next cycle
        end
        recCopy: begin
          stepCnt <= stepCnt + 1'b1;
          if (stepCnt == recoverSteps - 1) state <= recIdle;
        end
      endcase
    end
  end

endmodule

/* rtl/mapRam4r4w.sv */
/* flop based logical to physical map, one entry per logical reg
   reads are combinational, writes land at the clock edge
   same address on two write ports: the higher port number wins
   reset loads the identity map */
module mapRam4r4w (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [renamePkg::logRegBits-1:0]  rdAddr0_i,
  input  logic [renamePkg::logRegBits-1:0]  rdAddr1_i,
  input  logic [renamePkg::logRegBits-1:0]  rdAddr2_i,
  input  logic [renamePkg::logRegBits-1:0]  rdAddr3_i,
  output logic [renamePkg::physRegBits-1:0] rdData0_o,
  output logic [renamePkg::physRegBits-1:0] rdData1_o,
  output logic [renamePkg::physRegBits-1:0] rdData2_o,
  output logic [renamePkg::physRegBits-1:0] rdData3_o,
  input  logic                              we0_i,
  input  logic                              we1_i,
  input  logic                              we2_i,
  input  logic                              we3_i,
  input  logic [renamePkg::logRegBits-1:0]  wrAddr0_i,
  input  logic [renamePkg::logRegBits-1:0]  wrAddr1_i,
  input  logic [renamePkg::logRegBits-1:0]  wrAddr2_i,
  input  logic [renamePkg::logRegBits-1:0]  wrAddr3_i,
  input  logic [renamePkg::physRegBits-1:0] wrData0_i,
  input  logic [renamePkg::physRegBits-1:0] wrData1_i,
  input  logic [renamePkg::physRegBits-1:0] wrData2_i,
  input  logic [renamePkg::physRegBits-1:0] wrData3_i
);
  import renamePkg::*;

  logic [physRegBits-1:0] mem [numLogRegs];

  assign rdData0_o = mem[rdAddr0_i];  // old value, write not bypassed
  assign rdData1_o = mem[rdAddr1_i];
  assign rdData2_o = mem[rdAddr2_i];
  assign rdData3_o = mem[rdAddr3_i];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < numLogRegs; i++) begin
        mem[i] <= physRegBits'(i);  // logical i -> physical i
      end
    end else begin
      // later statements override earlier ones, so port 3 has priority
      if (we0_i) mem[wrAddr0_i] <= wrData0_i;
      if (we1_i) mem[wrAddr1_i] <= wrData1_i;
      if (we2_i) mem[wrAddr2_i] <= wrData2_i;
      if (we3_i) mem[wrAddr3_i] <= wrData3_i;
    end
  end

endmodule

/* rtl/recoverPkg.sv */
/* recovery sequencer encoding
   one copy step moves four map entries */
package recoverPkg;

  typedef enum logic {
    recIdle,  // normal operation
    recCopy   // streaming the architectural map out
  } recoverState_t;

  // 32 logical regs, four per cycle
  localparam int recoverSteps = 8;

endpackage

/* rtl/renameCore.sv */
/* rename subsystem top with rename map, free list and architectural map
   rename results arrive 1 cycle after the request
   releases come in the commit cycle
   recoverBusy_o spans 8 cycles from the cycle after recover_i */
module renameCore (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              renameValid_i,
  input  logic [renamePkg::logRegBits-1:0]  renameSrcA_i,
  input  logic [renamePkg::logRegBits-1:0]  renameSrcB_i,
  input  logic [renamePkg::logRegBits-1:0]  renameDest_i,
  input  logic                              renameHasDest_i,
  output logic                              renameDone_o,
  output logic [renamePkg::physRegBits-1:0] physSrcA_o,
  output logic [renamePkg::physRegBits-1:0] physSrcB_o,
  output logic [renamePkg::physRegBits-1:0] physDest_o,
  output logic [renamePkg::physRegBits-1:0] oldPhysDest_o,
  input  logic                              commitValid0_i,
  input  logic                              commitValid1_i,
  input  logic                              commitValid2_i,
  input  logic                              commitValid3_i,
  input  logic [renamePkg::logRegBits-1:0]  commitLogDest0_i,
  input  logic [renamePkg::logRegBits-1:0]  commitLogDest1_i,
  input  logic [renamePkg::logRegBits-1:0]  commitLogDest2_i,
  input  logic [renamePkg::logRegBits-1:0]  commitLogDest3_i,
  input  logic [renamePkg::physRegBits-1:0] commitPhysDest0_i,
  input  logic [renamePkg::physRegBits-1:0] commitPhysDest1_i,
  input  logic [renamePkg::physRegBits-1:0] commitPhysDest2_i,
  input  logic [renamePkg::physRegBits-1:0] commitPhysDest3_i,
  output logic                              releasedValid0_o,
  output logic                              releasedValid1_o,
  output logic                              releasedValid2_o,
  output logic                              releasedValid3_o,
  output logic [renamePkg::physRegBits-1:0] releasedPhys0_o,
  output logic [renamePkg::physRegBits-1:0] releasedPhys1_o,
  output logic [renamePkg::physRegBits-1:0] releasedPhys2_o,
  output logic [renamePkg::physRegBits-1:0] releasedPhys3_o,
  input  logic                              recover_i,
  output logic                              recoverBusy_o
);
  import renamePkg::*;

  logic                                allocReq, freeEmpty, recoverWe;
  logic [physRegBits-1:0]              allocReg;
  logic [logRegBits-1:0]               recoverBase;
  logic [physRegBits-1:0]              recoverPhys0, recoverPhys1, recoverPhys2, recoverPhys3;
  logic [$clog2(commitWidth+1)-1:0]    commitCount;

  // count of retiring instructions with a destination
  assign commitCount = {2'b00, commitValid0_i} + {2'b00, commitValid1_i}
                     + {2'b00, commitValid2_i} + {2'b00, commitValid3_i};

  archMapTable i_archMapTable (
    .clk (clk), .reset (reset),
    .commitValid0_i (commitValid0_i), .commitValid1_i (commitValid1_i),
    .commitValid2_i (commitValid2_i), .commitValid3_i (commitValid3_i),
    .commitLogDest0_i (commitLogDest0_i), .commitLogDest1_i (commitLogDest1_i),
    .commitLogDest2_i (commitLogDest2_i), .commitLogDest3_i (commitLogDest3_i),
    .commitPhysDest0_i (commitPhysDest0_i), .commitPhysDest1_i (commitPhysDest1_i),
    .commitPhysDest2_i (commitPhysDest2_i), .commitPhysDest3_i (commitPhysDest3_i),
    .recover_i (recover_i),
    .releasedValid0_o (releasedValid0_o), .releasedValid1_o (releasedValid1_o),
    .releasedValid2_o (releasedValid2_o), .releasedValid3_o (releasedValid3_o),
    .releasedPhys0_o (releasedPhys0_o), .releasedPhys1_o (releasedPhys1_o),
    .releasedPhys2_o (releasedPhys2_o), .releasedPhys3_o (releasedPhys3_o),
    .recoverBusy_o (recoverBusy_o), .recoverWe_o (recoverWe), .recoverBase_o (recoverBase),
    .recoverPhys0_o (recoverPhys0), .recoverPhys1_o (recoverPhys1),
    .recoverPhys2_o (recoverPhys2), .recoverPhys3_o (recoverPhys3)
  );

  specFreeList i_specFreeList (
    .clk (clk), .reset (reset),
    .allocReq_i (allocReq), .allocReg_o (allocReg), .empty_o (freeEmpty),
    .releasedValid0_i (releasedValid0_o), .releasedValid1_i (releasedValid1_o),
    .releasedValid2_i (releasedValid2_o), .releasedValid3_i (releasedValid3_o),
    .releasedPhys0_i (releasedPhys0_o), .releasedPhys1_i (releasedPhys1_o),
    .releasedPhys2_i (releasedPhys2_o), .releasedPhys3_i (releasedPhys3_o),
    .commitCount_i (commitCount), .recover_i (recover_i)  // head restore on the strobe
  );

  renameMapTable i_renameMapTable (
    .clk (clk), .reset (reset),
    .renameValid_i (renameValid_i), .renameSrcA_i (renameSrcA_i),
    .renameSrcB_i (renameSrcB_i), .renameDest_i (renameDest_i),
    .renameHasDest_i (renameHasDest_i),
    .allocReg_i (allocReg), .allocOk_i (!freeEmpty), .allocReq_o (allocReq),
    .recoverWe_i (recoverWe), .recoverBase_i (recoverBase),
    .recoverPhys0_i (recoverPhys0), .recoverPhys1_i (recoverPhys1),
    .recoverPhys2_i (recoverPhys2), .recoverPhys3_i (recoverPhys3),
    .renameDone_o (renameDone_o), .physSrcA_o (physSrcA_o), .physSrcB_o (physSrcB_o),
    .physDest_o (physDest_o), .oldPhysDest_o (oldPhysDest_o)
  );

endmodule

/* rtl/renameMapTable.sv */
/* speculative map, one rename per cycle, results one cycle later
   a rename is dropped while the free list is empty or recovery writes run
   sources read the map before this rename's destination is written,
   so an instruction reading its own destination sees the old mapping */
module renameMapTable (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              renameValid_i,
  input  logic [renamePkg::logRegBits-1:0]  renameSrcA_i,
  input  logic [renamePkg::logRegBits-1:0]  renameSrcB_i,
  input  logic [renamePkg::logRegBits-1:0]  renameDest_i,
  input  logic                              renameHasDest_i,
  input  logic [renamePkg::physRegBits-1:0] allocReg_i,
  input  logic                              allocOk_i,
  output logic                              allocReq_o,
  input  logic                              recoverWe_i,
  input  logic [renamePkg::logRegBits-1:0]  recoverBase_i,
  input  logic [renamePkg::physRegBits-1:0] recoverPhys0_i,
  input  logic [renamePkg::physRegBits-1:0] recoverPhys1_i,
  input  logic [renamePkg::physRegBits-1:0] recoverPhys2_i,
  input  logic [renamePkg::physRegBits-1:0] recoverPhys3_i,
  output logic                              renameDone_o,
  output logic [renamePkg::physRegBits-1:0] physSrcA_o,
  output logic [renamePkg::physRegBits-1:0] physSrcB_o,
  output logic [renamePkg::physRegBits-1:0] physDest_o,
  output logic [renamePkg::physRegBits-1:0] oldPhysDest_o
);
  import renamePkg::*;

  logic [physRegBits-1:0] map [numLogRegs];
  logic                   accept;

  // the only place where recovery blocks renaming
  assign accept     = renameValid_i && allocOk_i && !recoverWe_i;
  assign allocReq_o = accept && renameHasDest_i;  // free list pops at the edge

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < numLogRegs; i++) begin
        map[i] <= physRegBits'(i);
      end
    end else if (recoverWe_i) begin
      map[recoverBase_i]                   <= recoverPhys0_i;  // group of four
      map[recoverBase_i + logRegBits'(1)] <= recoverPhys1_i;
      map[recoverBase_i + logRegBits'(2)] <= recoverPhys2_i;
      map[recoverBase_i + logRegBits'(3)] <= recoverPhys3_i;
    end else if (allocReq_o) begin
      map[renameDest_i] <= allocReg_i;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      renameDone_o <= 1'b0;
    end else begin
      renameDone_o <= accept;
    end
  end

  // payload, only meaningful with renameDone_o
  always_ff @(posedge clk) begin
    physSrcA_o    <= map[renameSrcA_i];
    physSrcB_o    <= map[renameSrcB_i];
    physDest_o    <= allocReg_i;          // don't care without a destination
    oldPhysDest_o <= map[renameDest_i];   // freed later when this commits
  end

endmodule

/* rtl/renamePkg.sv */
/* sizing shared by every rename block
   logical regs start mapped to the physical reg of the same number,
   so physical regs numLogRegs and up form the initial free pool
   commitWidth also sets the number of recovery entries per cycle */
package renamePkg;

  localparam int numLogRegs  = 32;  // architectural register count
  localparam int logRegBits  = 5;   // logical index width

  localparam int numPhysRegs = 64;  // physical register file size
  localparam int physRegBits = 6;   // physical index width

  // instructions retired per cycle, one release slot each
  localparam int commitWidth = 4;

  // free regs after reset, physical 32..63
  localparam int numFreeRegs = numPhysRegs - numLogRegs;

endpackage

/* rtl/specFreeList.sv */
/* circular free list of physical regs
   allocReg_o is valid whenever empty_o is low; the head moves at the edge
   released regs are pushed at the tail in slot order, gaps removed
   commitHead trails specHead by the allocations not yet committed;
   recover_i winds specHead back to it */
module specFreeList #(
  parameter int depth = renamePkg::numFreeRegs
) (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              allocReq_i,
  output logic [renamePkg::physRegBits-1:0] allocReg_o,
  output logic                              empty_o,
  input  logic                              releasedValid0_i,
  input  logic                              releasedValid1_i,
  input  logic                              releasedValid2_i,
  input  logic                              releasedValid3_i,
  input  logic [renamePkg::physRegBits-1:0] releasedPhys0_i,
  input  logic [renamePkg::physRegBits-1:0] releasedPhys1_i,
  input  logic [renamePkg::physRegBits-1:0] releasedPhys2_i,
  input  logic [renamePkg::physRegBits-1:0] releasedPhys3_i,
  input  logic [$clog2(renamePkg::commitWidth+1)-1:0] commitCount_i,
  input  logic                              recover_i
);
  import renamePkg::*;

  typedef logic [$clog2(depth)-1:0]   ptr_t;
  typedef logic [$clog2(depth+1)-1:0] cnt_t;

  logic [physRegBits-1:0] mem [depth];
  ptr_t specHead, commitHead, tail;
  cnt_t freeCnt;   // regs between specHead and tail
  cnt_t inFlight;  // allocated but not yet committed
  logic [2:0] off1, off2, off3, pushCnt;  // compacted push offsets

  // pointer add modulo depth, depth need not be a power of two
  function automatic ptr_t ptrAdd(input ptr_t ptr, input logic [2:0] inc);
    logic [$clog2(depth):0] sum;
    sum = ptr + inc;
    return (sum >= depth) ? ptr_t'(sum - depth) : ptr_t'(sum);
  endfunction

  assign off1    = {2'b00, releasedValid0_i};
  assign off2    = off1 + {2'b00, releasedValid1_i};
  assign off3    = off2 + {2'b00, releasedValid2_i};
  assign pushCnt = off3 + {2'b00, releasedValid3_i};

  assign allocReg_o = mem[specHead];
  assign empty_o    = (freeCnt == '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      specHead   <= '0;
      commitHead <= '0;
      tail       <= '0;  // full, so tail wraps onto head
      freeCnt    <= cnt_t'(depth);
      inFlight   <= '0;
      for (int i = 0; i < depth; i++) begin
        mem[i] <= physRegBits'(numLogRegs + i);
      end
    end else begin
      if (releasedValid0_i) mem[tail] <= releasedPhys0_i;
      if (releasedValid1_i) mem[ptrAdd(tail, off1)] <= releasedPhys1_i;
      if (releasedValid2_i) mem[ptrAdd(tail, off2)] <= releasedPhys2_i;
      if (releasedValid3_i) mem[ptrAdd(tail, off3)] <= releasedPhys3_i;
      tail       <= ptrAdd(tail, pushCnt);
      commitHead <= ptrAdd(commitHead, commitCount_i);
      if (recover_i) begin
        // wrong-path allocations return to the pool
        specHead <= ptrAdd(commitHead, commitCount_i);
        freeCnt  <= freeCnt + inFlight + cnt_t'(pushCnt) - cnt_t'(commitCount_i);
        inFlight <= '0;
      end else begin
        if (allocReq_i) specHead <= ptrAdd(specHead, 3'd1);
        freeCnt  <= freeCnt + cnt_t'(pushCnt) - cnt_t'(allocReq_i);
        inFlight <= inFlight + cnt_t'(allocReq_i) - cnt_t'(commitCount_i);
      end
    end
  end

endmodule

/* test/renameCoreTb.sv */
/* testbench for renameCore that plays the active list
   inputs change 1 unit after the rising edge
   outputs are checked at the falling edge
   renames always carry a destination except where noted
   commits retire renamed instructions in program order */
module renameCoreTb;
  import renamePkg::*;

  logic clk = 1'b0;
  logic reset;
  logic renameValid_i, renameHasDest_i, recover_i;
  logic [logRegBits-1:0] renameSrcA_i, renameSrcB_i, renameDest_i;
  logic renameDone_o, recoverBusy_o;
  logic [physRegBits-1:0] physSrcA_o, physSrcB_o, physDest_o, oldPhysDest_o;
  logic commitValid0_i, commitValid1_i, commitValid2_i, commitValid3_i;
  logic [logRegBits-1:0] commitLogDest0_i, commitLogDest1_i, commitLogDest2_i, commitLogDest3_i;
  logic [physRegBits-1:0] commitPhysDest0_i, commitPhysDest1_i;
  logic [physRegBits-1:0] commitPhysDest2_i, commitPhysDest3_i;
  logic releasedValid0_o, releasedValid1_o, releasedValid2_o, releasedValid3_o;
  logic [physRegBits-1:0] releasedPhys0_o, releasedPhys1_o, releasedPhys2_o, releasedPhys3_o;

  // reference model
  logic [physRegBits-1:0] specMap [numLogRegs];
  logic [physRegBits-1:0] archMap [numLogRegs];
  logic [physRegBits-1:0] freeQ [$];    // allocation order
  logic [physRegBits-1:0] robPhys [$];  // renamed but not yet committed
  logic [logRegBits-1:0]  robLog [$];
  logic [31:0] lcgState = 32'd2242;

  // pend* becomes exp* one cycle later
  logic expDone, expHasDest, pendDone, pendHasDest, inRecovery;
  logic [physRegBits-1:0] expSrcA, expSrcB, expDest, expOld;
  logic [physRegBits-1:0] pendSrcA, pendSrcB, pendDest, pendOld;
  logic [3:0] expRelV;
  logic [physRegBits-1:0] expRelP [4];
  string testName = "reset";
  int errCnt = 0, errAtStart = 0, testCnt = 0, failTests = 0;

  always #2 clk = ~clk;

  renameCore i_renameCore (.*);

  task automatic reportMismatch(input string what, input int expV, input int actV);
    errCnt++;
    $display("Mismatch in %s: %s expected %0d, actual %0d", testName, what, expV, actV);
  endtask

  assert property (@(negedge clk) disable iff (reset) renameDone_o == expDone)
    else reportMismatch("renameDone_o", expDone, renameDone_o);
  assert property (@(negedge clk) disable iff (reset) expDone |-> physSrcA_o == expSrcA)
    else reportMismatch("physSrcA_o", expSrcA, physSrcA_o);
  assert property (@(negedge clk) disable iff (reset) expDone |-> physSrcB_o == expSrcB)
    else reportMismatch("physSrcB_o", expSrcB, physSrcB_o);
  assert property (@(negedge clk) disable iff (reset)
                   expDone && expHasDest |-> physDest_o == expDest)
    else reportMismatch("physDest_o", expDest, physDest_o);
  assert property (@(negedge clk) disable iff (reset)
                   expDone && expHasDest |-> oldPhysDest_o == expOld)
    else reportMismatch("oldPhysDest_o", expOld, oldPhysDest_o);
  assert property (@(negedge clk) disable iff (reset)
                   {releasedValid3_o, releasedValid2_o, releasedValid1_o, releasedValid0_o}
                   == expRelV)
    else reportMismatch("releasedValid", expRelV, {releasedValid3_o, releasedValid2_o,
                                                   releasedValid1_o, releasedValid0_o});
  assert property (@(negedge clk) disable iff (reset) expRelV[0] |-> releasedPhys0_o == expRelP[0])
    else reportMismatch("releasedPhys0_o", expRelP[0], releasedPhys0_o);
  assert property (@(negedge clk) disable iff (reset) expRelV[1] |-> releasedPhys1_o == expRelP[1])
    else reportMismatch("releasedPhys1_o", expRelP[1], releasedPhys1_o);
  assert property (@(negedge clk) disable iff (reset) expRelV[2] |-> releasedPhys2_o == expRelP[2])
    else reportMismatch("releasedPhys2_o", expRelP[2], releasedPhys2_o);
  assert property (@(negedge clk) disable iff (reset) expRelV[3] |-> releasedPhys3_o == expRelP[3])
    else reportMismatch("releasedPhys3_o", expRelP[3], releasedPhys3_o);
  assert property (@(negedge clk) disable iff (reset) !inRecovery |-> !recoverBusy_o)
    else reportMismatch("recoverBusy_o", 0, recoverBusy_o);

  function automatic logic [logRegBits-1:0] randReg();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState[20:16];  // low LCG bits repeat quickly
  endfunction

  // one clock later strobes drop and last cycle's rename becomes checkable
  task automatic nextCycle();
    @(posedge clk);
    #1;
    expDone = pendDone;
    expHasDest = pendHasDest;
    expSrcA = pendSrcA;
    expSrcB = pendSrcB;
    expDest = pendDest;
    expOld = pendOld;
    pendDone = 1'b0;
    expRelV = 4'b0000;
    renameValid_i = 1'b0;
    recover_i = 1'b0;
    {commitValid3_i, commitValid2_i, commitValid1_i, commitValid0_i} = 4'b0000;
  endtask

  task automatic renameOne(input logic [logRegBits-1:0] srcA, input logic [logRegBits-1:0] srcB,
                           input logic [logRegBits-1:0] dest, input logic hasDest);
    nextCycle();
    renameValid_i = 1'b1;
    renameSrcA_i = srcA;
    renameSrcB_i = srcB;
    renameDest_i = dest;
    renameHasDest_i = hasDest;
    pendDone = 1'b1;
    pendHasDest = hasDest;
    pendSrcA = specMap[srcA];  // sources see the map before this dest
    pendSrcB = specMap[srcB];
    pendOld = specMap[dest];
    if (hasDest) begin
      pendDest = freeQ.pop_front();
      specMap[dest] = pendDest;
      robLog.push_back(dest);
      robPhys.push_back(pendDest);
    end
  endtask

  // retire the oldest renamed instructions into the slots set in mask
  task automatic commitWindow(input logic [3:0] mask);
    logic [logRegBits-1:0]  ld [4];
    logic [physRegBits-1:0] pd [4];
    logic squashed;
    nextCycle();
    for (int s = 0; s < 4; s++) begin
      ld[s] = '0;
      pd[s] = '0;
      if (mask[s]) begin
        ld[s] = robLog.pop_front();
        pd[s] = robPhys.pop_front();
      end
    end
    for (int s = 0; s < 4; s++) begin
      squashed = 1'b0;
      for (int t = s + 1; t < 4; t++) begin
        if (mask[t] && ld[t] == ld[s]) squashed = 1'b1;  // a younger slot wins
      end
      expRelP[s] = squashed ? pd[s] : archMap[ld[s]];  // map before this window
    end
    for (int s = 0; s < 4; s++) begin
      if (mask[s]) begin
        archMap[ld[s]] = pd[s];
        freeQ.push_back(expRelP[s]);  // pushed in slot order
      end
    end
    expRelV = mask;
    commitValid0_i = mask[0];
    commitLogDest0_i = ld[0];
    commitPhysDest0_i = pd[0];
    commitValid1_i = mask[1];
    commitLogDest1_i = ld[1];
    commitPhysDest1_i = pd[1];
    commitValid2_i = mask[2];
    commitLogDest2_i = ld[2];
    commitPhysDest2_i = pd[2];
    commitValid3_i = mask[3];
    commitLogDest3_i = ld[3];
    commitPhysDest3_i = pd[3];
  endtask

  task automatic recoverAll();
    int busyCnt;
    nextCycle();
    recover_i = 1'b1;
    inRecovery = 1'b1;
    for (int i = 0; i < numLogRegs; i++) specMap[i] = archMap[i];
    for (int i = robPhys.size() - 1; i >= 0; i--) begin
      freeQ.push_front(robPhys[i]);  // wrong-path regs go back first
    end
    robPhys.delete();
    robLog.delete();
    nextCycle();
    busyCnt = 0;
    while (recoverBusy_o && busyCnt < 32) begin
      busyCnt++;
      nextCycle();
    end
    if (recoverBusy_o) begin
      errCnt++;
      $display("Error in %s: recoverBusy_o still high after %0d cycles", testName, busyCnt);
    end
    assert (busyCnt == 8)  // 32 logical regs, four per cycle
      else reportMismatch("recoverBusy_o cycles", 8, busyCnt);
    inRecovery = 1'b0;
  endtask

  task automatic startTest(input string name);
    testName = name;
    errAtStart = errCnt;
  endtask

  task automatic endTest();
    nextCycle();
    nextCycle();  // last registered result reaches its check
    testCnt++;
    if (errCnt == errAtStart) begin
      $display("test %s: ok", testName);
    end else begin
      failTests++;
      $display("test %s: %0d errors", testName, errCnt - errAtStart);
    end
  endtask

  initial begin
    reset = 1'b1;
    renameValid_i = 1'b0;
    renameHasDest_i = 1'b0;
    renameSrcA_i = '0;
    renameSrcB_i = '0;
    renameDest_i = '0;
    recover_i = 1'b0;
    {commitValid3_i, commitValid2_i, commitValid1_i, commitValid0_i} = 4'b0000;
    {commitLogDest3_i, commitLogDest2_i, commitLogDest1_i, commitLogDest0_i} = '0;
    {commitPhysDest3_i, commitPhysDest2_i, commitPhysDest1_i, commitPhysDest0_i} = '0;
    {expDone, expHasDest, pendDone, pendHasDest, inRecovery} = '0;
    {expSrcA, expSrcB, expDest, expOld, pendSrcA, pendSrcB, pendDest, pendOld} = '0;
    expRelV = 4'b0000;
    for (int i = 0; i < numLogRegs; i++) begin
      specMap[i] = physRegBits'(i);
      archMap[i] = physRegBits'(i);
      freeQ.push_back(physRegBits'(numLogRegs + i));  // 32..63 free after reset
    end
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;

    startTest("identity");
    for (int i = 0; i < 6; i++) renameOne(randReg(), randReg(), 5'(3 * i + 1), 1'b1);
    endTest();
    startTest("newMapping");
    renameOne(randReg(), randReg(), 5'd7, 1'b1);  // r7 renamed a second time
    renameOne(5'd7, randReg(), 5'd20, 1'b1);
    renameOne(5'd20, 5'd7, 5'd0, 1'b0);  // no destination so no allocation
    endTest();
    startTest("commitUnique");
    commitWindow(4'b1101);
    commitWindow(4'b0111);
    endTest();
    startTest("commitSameDest");
    for (int i = 0; i < 4; i++) renameOne(randReg(), randReg(), 5'd9, 1'b1);
    commitWindow(4'b1111);
    commitWindow(4'b0011);
    endTest();
    startTest("freeListWrap");
    for (int i = 0; i < 24; i++) begin
      renameOne(randReg(), randReg(), randReg(), 1'b1);
      if (i % 4 == 3) commitWindow(4'b1111);
    end
    endTest();
    startTest("recovery");
    for (int i = 0; i < 6; i++) renameOne(randReg(), randReg(), randReg(), 1'b1);
    commitWindow(4'b0011);
    recoverAll();
    for (int i = 0; i < 4; i++) renameOne(randReg(), randReg(), randReg(), 1'b1);
    endTest();

    $display("tests %0d, failed %0d, errors %0d", testCnt, failTests, errCnt);
    if (errCnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
